// ==== common/soc_pkg.sv ====
// All bus addresses are word addresses; byte lane selection is carried in bytesel only
package soc_pkg;

    localparam int addr_width    = 19;   // Byte address bits 19..1
    localparam int data_width    = 16;
    localparam int io_addr_width = 15;   // I/O byte address bits 15..1
    localparam int num_leds      = 8;

    // Target depths in words
    localparam int bios_words = 8192;    // 16 KiB shadow
    localparam int ram_words  = 4096;

    // Overlay window FC000h..FFFFFh, as a word address
    localparam logic [addr_width-1:0] bios_base = 19'h7e000;

    // I/O ports, word addresses
    localparam logic [io_addr_width-1:0] leds_port      = 15'h7fff; // FFFEh
    localparam logic [io_addr_width-1:0] bios_ctrl_port = 15'h7ff6; // FFECh

    // Request fields, held stable while access is high
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic                  wr_en;
        logic [1:0]            bytesel;  // Bit 0 is the low byte
    } bus_req_t;

    // Target answer, rdata is zero unless ack is set
    typedef struct packed {
        logic                  ack;
        logic [data_width-1:0] rdata;
    } bus_rsp_t;

endpackage

// ==== hw/onchip_ram.sv ====
// Depth must be a power of two; addresses wrap modulo depth and array contents are undefined after power up
`timescale 1ns/100ps

module onchip_ram #(
    parameter int depth = 4096
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              access,
    input  logic              sel,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp
);

    localparam int idx_width = $clog2(depth);

    logic [soc_pkg::data_width-1:0] mem [depth];
    logic [soc_pkg::data_width-1:0] rdata_q;
    logic [idx_width-1:0]           idx;
    logic                           ack_q;
    logic                           start;

    assign idx = req.addr[idx_width-1:0];   // Wraps modulo depth

    // One transfer per held access, the ack cycle blocks a second one
    assign start = access && sel && !ack_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rdata_q <= mem[idx];
            if (req.wr_en && req.bytesel[0]) begin
                mem[idx][7:0] <= req.wdata[7:0];
            end
            if (req.wr_en && req.bytesel[1]) begin
                mem[idx][15:8] <= req.wdata[15:8];
            end
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = ack_q ? rdata_q : '0;    // Zero outside ack for OR merging

endmodule

// ==== hw/mem_arbiter.sv ====
// Masters must hold access until ack and drop it for a cycle afterwards; data port wins ties
`timescale 1ns/100ps

module mem_arbiter (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_access,
    input  logic              data_access,
    input  logic              bios_enabled,
    input  soc_pkg::bus_req_t instr_req,
    input  soc_pkg::bus_req_t data_req,
    output soc_pkg::bus_rsp_t instr_rsp,
    output soc_pkg::bus_rsp_t data_rsp,
    output logic              q_access,
    output logic              bios_sel,
    output logic              ram_sel,
    output soc_pkg::bus_req_t q_req,
    input  soc_pkg::bus_rsp_t bios_rsp,
    input  soc_pkg::bus_rsp_t ram_rsp
);

    typedef enum logic [1:0] {
        grant_idle,
        grant_instr,
        grant_data
    } grant_t;

    grant_t            grant;
    soc_pkg::bus_rsp_t q_rsp;
    logic              bios_hit;

    // Unselected targets drive zero, so a plain OR merges them
    assign q_rsp = soc_pkg::bus_rsp_t'(bios_rsp | ram_rsp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant <= grant_idle;
        end else begin
            case (grant)
                grant_idle: begin
                    if (data_access) begin
                        grant <= grant_data;
                    end else if (instr_access) begin
                        grant <= grant_instr;
                    end
                end
                default: begin
                    // Back to idle after every transfer so neither port starves
                    if (q_rsp.ack) begin
                        grant <= grant_idle;
                    end
                end
            endcase
        end
    end

    // Shared bus request
    always_comb begin
        case (grant)
            grant_instr: begin
                q_req         = '0;             // Fetches never write
                q_req.addr    = instr_req.addr;
                q_req.bytesel = 2'b11;          // Whole word fetch
            end
            grant_data: begin
                q_req = data_req;
            end
            default: begin
                q_req = '0;
            end
        endcase
    end

    assign q_access = (grant != grant_idle);

    // Top 16 KiB goes to the shadow while the overlay is on
    assign bios_hit = bios_enabled && (q_req.addr >= soc_pkg::bios_base);
    assign bios_sel = q_access && bios_hit;
    assign ram_sel  = q_access && !bios_hit;

    // Only the granted port sees the answer
    assign instr_rsp = (grant == grant_instr) ? q_rsp : '0;
    assign data_rsp  = (grant == grant_data) ? q_rsp : '0;

endmodule

// ==== hw/io_decoder.sv ====
// Every unmapped I/O port is acked one cycle after access and reads as zero
`timescale 1ns/100ps

module io_decoder (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              io_access,
    input  logic [soc_pkg::io_addr_width-1:0] io_addr,
    output logic                              leds_sel,
    output logic                              bios_ctrl_sel,
    input  soc_pkg::bus_rsp_t                 regs_rsp,
    output soc_pkg::bus_rsp_t                 io_rsp
);

    logic default_sel;
    logic default_ack;

    // Register selects, qualified by io_access in io_regs
    always_comb begin
        leds_sel      = 1'b0;
        bios_ctrl_sel = 1'b0;
        default_sel   = 1'b0;

        case (io_addr)
            soc_pkg::leds_port: begin
                leds_sel = 1'b1;
            end
            soc_pkg::bios_ctrl_port: begin
                bios_ctrl_sel = 1'b1;
            end
            default: begin
                default_sel = io_access;
            end
        endcase
    end

    // Default responder
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_sel && !default_ack;   // Single pulse per access
        end
    end

    // Default responder never returns data
    assign io_rsp.ack   = regs_rsp.ack | default_ack;
    assign io_rsp.rdata = regs_rsp.rdata;

endmodule

// ==== hw/io_regs.sv ====
// Only the low byte lane is writable; the overlay is enabled and the LEDs are off after reset
`timescale 1ns/100ps

module io_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         io_access,
    input  logic                         leds_sel,
    input  logic                         bios_ctrl_sel,
    input  soc_pkg::bus_req_t            io_req,
    output soc_pkg::bus_rsp_t            regs_rsp,
    output logic [soc_pkg::num_leds-1:0] leds,
    output logic                         bios_enabled
);

    logic                           start;
    logic                           ack_q;
    logic                           wr_low;
    logic [soc_pkg::data_width-1:0] rdata_q;

    assign start  = io_access && (leds_sel || bios_ctrl_sel) && !ack_q;
    assign wr_low = start && io_req.wr_en && io_req.bytesel[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q        <= 1'b0;
            leds         <= '0;
            bios_enabled <= 1'b1;   // Boot from the shadow
        end else begin
            ack_q <= start;
            if (wr_low && leds_sel) begin
                leds <= io_req.wdata[soc_pkg::num_leds-1:0];
            end
            if (wr_low && bios_ctrl_sel) begin
                bios_enabled <= io_req.wdata[0];
            end
        end
    end

    // Read value captured with the access
    always_ff @(posedge clk) begin
        if (start) begin
            if (leds_sel) begin
                rdata_q <= {{(soc_pkg::data_width - soc_pkg::num_leds){1'b0}}, leds};
            end else begin
                rdata_q <= {{(soc_pkg::data_width - 1){1'b0}}, bios_enabled};
            end
        end
    end

    assign regs_rsp.ack   = ack_q;
    assign regs_rsp.rdata = ack_q ? rdata_q : '0;

endmodule

// ==== hw/soc_top.sv ====
// No registers at this level; latency comes from the arbiter and the targets only
`timescale 1ns/100ps

module soc_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         instr_access,
    input  soc_pkg::bus_req_t            instr_req,
    output soc_pkg::bus_rsp_t            instr_rsp,
    input  logic                         data_access,
    input  logic                         data_io,
    input  soc_pkg::bus_req_t            data_req,
    output soc_pkg::bus_rsp_t            data_rsp,
    output logic [soc_pkg::num_leds-1:0] leds
);

    logic              mem_access;
    logic              io_access;
    soc_pkg::bus_rsp_t mem_rsp;
    soc_pkg::bus_rsp_t io_rsp;

    // Shared memory bus
    logic              q_access;
    soc_pkg::bus_req_t q_req;
    logic              bios_sel;
    logic              ram_sel;
    soc_pkg::bus_rsp_t bios_rsp;
    soc_pkg::bus_rsp_t ram_rsp;

    logic              leds_sel;
    logic              bios_ctrl_sel;
    logic              bios_enabled;
    soc_pkg::bus_rsp_t regs_rsp;

    // Data port split by address space
    assign mem_access = data_access && !data_io;
    assign io_access  = data_access && data_io;
    assign data_rsp   = soc_pkg::bus_rsp_t'(mem_rsp | io_rsp);

    mem_arbiter i_mem_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_access (instr_access),
        .data_access  (mem_access),
        .bios_enabled (bios_enabled),
        .instr_req    (instr_req),
        .data_req     (data_req),
        .instr_rsp    (instr_rsp),
        .data_rsp     (mem_rsp),
        .q_access     (q_access),
        .bios_sel     (bios_sel),
        .ram_sel      (ram_sel),
        .q_req        (q_req),
        .bios_rsp     (bios_rsp),
        .ram_rsp      (ram_rsp)
    );

    onchip_ram #(.depth(soc_pkg::bios_words)) i_bios_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .access (q_access),
        .sel    (bios_sel),
        .req    (q_req),
        .rsp    (bios_rsp)
    );

    onchip_ram #(.depth(soc_pkg::ram_words)) i_sys_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .access (q_access),
        .sel    (ram_sel),
        .req    (q_req),
        .rsp    (ram_rsp)
    );

    io_decoder i_io_decoder (
        .clk           (clk),
        .arst_n        (arst_n),
        .io_access     (io_access),
        .io_addr       (data_req.addr[soc_pkg::io_addr_width-1:0]),
        .leds_sel      (leds_sel),
        .bios_ctrl_sel (bios_ctrl_sel),
        .regs_rsp      (regs_rsp),
        .io_rsp        (io_rsp)
    );

    io_regs i_io_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .io_access     (io_access),
        .leds_sel      (leds_sel),
        .bios_ctrl_sel (bios_ctrl_sel),
        .io_req        (data_req),
        .regs_rsp      (regs_rsp),
        .leds          (leds),
        .bios_enabled  (bios_enabled)
    );

endmodule

// ==== tb/soc_sva.sv ====
// Bound into soc_top; properties are off while arst_n is low
`timescale 1ns/100ps

module soc_sva (
    input logic              clk,
    input logic              arst_n,
    input soc_pkg::bus_rsp_t instr_rsp,
    input soc_pkg::bus_rsp_t data_rsp,
    input soc_pkg::bus_rsp_t bios_rsp,
    input soc_pkg::bus_rsp_t ram_rsp,
    input soc_pkg::bus_rsp_t io_rsp,
    input logic              q_access,
    input logic              bios_sel,
    input logic              ram_sel,
    input soc_pkg::bus_req_t q_req
);

    int         fail_count = 0;
    logic       q_ack;
    logic [4:0] acks;
    logic       rdata_clean;

    assign q_ack = bios_rsp.ack || ram_rsp.ack;
    assign acks  = {instr_rsp.ack, data_rsp.ack, bios_rsp.ack, ram_rsp.ack, io_rsp.ack};

    // Idle responses carry no data on any path
    assign rdata_clean = (instr_rsp.ack || instr_rsp.rdata == '0)
                      && (data_rsp.ack || data_rsp.rdata == '0)
                      && (bios_rsp.ack || bios_rsp.rdata == '0)
                      && (ram_rsp.ack || ram_rsp.rdata == '0)
                      && (io_rsp.ack || io_rsp.rdata == '0);

    ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (acks & $past(acks)) == '0)
    else begin
        fail_count++;
        $error("ack held for more than one cycle");
    end

    sel_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(bios_sel && ram_sel))
    else begin
        fail_count++;
        $error("boot ROM shadow and RAM selected together");
    end

    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (q_access && !q_ack) |=> $stable(q_req))
    else begin
        fail_count++;
        $error("shared bus request changed before ack");
    end

    rdata_zero: assert property (@(posedge clk) disable iff (!arst_n) rdata_clean)
    else begin
        fail_count++;
        $error("nonzero read data without ack");
    end

endmodule

bind soc_top soc_sva i_soc_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr_rsp (instr_rsp),
    .data_rsp  (data_rsp),
    .bios_rsp  (bios_rsp),
    .ram_rsp   (ram_rsp),
    .io_rsp    (io_rsp),
    .q_access  (q_access),
    .bios_sel  (bios_sel),
    .ram_sel   (ram_sel),
    .q_req     (q_req)
);

// ==== tb/soc_tb.sv ====
// Run from the project root so tb/soc_stim.txt is found; stimulus fields are hex, seven per line
`timescale 1ns/100ps

module soc_tb;

    localparam int fields    = 7;    // test, port, rw, byte address, wdata, bytesel, expected
    localparam int max_lines = 64;
    localparam int ack_limit = 20;   // Cycles before an access counts as lost

    logic                         clk = 1'b0;
    logic                         arst_n;
    logic                         instr_access;
    soc_pkg::bus_req_t            instr_req;
    soc_pkg::bus_rsp_t            instr_rsp;
    logic                         data_access;
    logic                         data_io;
    soc_pkg::bus_req_t            data_req;
    soc_pkg::bus_rsp_t            data_rsp;
    logic [soc_pkg::num_leds-1:0] leds;

    logic [31:0] stim [fields*max_lines];
    int          num_lines    = 0;
    int          errors       = 0;   // Current test
    int          other_errors = 0;   // Outside any test

    always #50 clk = ~clk;

    soc_top i_soc_top (.*);

    function automatic logic [31:0] field(int line, int idx);
        return stim[line*fields + idx];
    endfunction

    // Request fields for one stimulus line
    function automatic soc_pkg::bus_req_t line_req(int line);
        soc_pkg::bus_req_t req;
        logic [31:0]       byte_addr;
        logic [31:0]       wdata;
        logic [31:0]       bytesel;
        byte_addr   = field(line, 3);
        wdata       = field(line, 4);
        bytesel     = field(line, 5);
        req.addr    = byte_addr[soc_pkg::addr_width:1];
        req.wdata   = wdata[soc_pkg::data_width-1:0];
        req.wr_en   = (field(line, 2) != 0);
        req.bytesel = bytesel[1:0];
        return req;
    endfunction

    // Counts falling edges until ack, so cycles is one more than the latency
    task automatic wait_ack(input logic on_instr, output int cycles, output logic [15:0] rdata);
        soc_pkg::bus_rsp_t rsp;
        cycles = 0;
        rdata  = '0;
        do begin
            @(negedge clk);
            cycles++;
            rsp = on_instr ? instr_rsp : data_rsp;
        end while (!rsp.ack && cycles < ack_limit);
        if (rsp.ack) begin
            rdata = rsp.rdata;
        end else begin
            $display("%0s port saw no ack within %0d cycles at %0t",
                     on_instr ? "instruction" : "data", ack_limit, $time);
            errors++;
        end
    endtask

    task automatic fetch(input int line);
        int          cycles;
        logic [15:0] got;
        repeat ($urandom % 4) @(posedge clk);   // Gap of 0 to 3 cycles
        @(posedge clk);
        instr_access <= 1'b1;
        instr_req    <= line_req(line);
        wait_ack(1'b1, cycles, got);
        if ({16'h0, got} !== field(line, 6)) begin
            $display("mismatch at %0t: fetch line %0d read %h, expected %h",
                     $time, line, got, field(line, 6));
            errors++;
        end
        @(posedge clk);
        instr_access <= 1'b0;
        instr_req    <= '0;
    endtask

    task automatic data_transfer(input int line);
        soc_pkg::bus_req_t req;
        logic              is_io;
        int                cycles;
        logic [15:0]       got;
        req   = line_req(line);
        is_io = (field(line, 1) == 2);
        @(posedge clk);
        data_access <= 1'b1;
        data_io     <= is_io;
        data_req    <= req;
        wait_ack(1'b0, cycles, got);
        if (!req.wr_en && {16'h0, got} !== field(line, 6)) begin
            $display("mismatch at %0t: data line %0d read %h, expected %h",
                     $time, line, got, field(line, 6));
            errors++;
        end
        // Expected column holds the LED value after an I/O write
        if (is_io && req.wr_en && {24'h0, leds} !== field(line, 6)) begin
            $display("mismatch at %0t: leds %h after line %0d, expected %h",
                     $time, leds, line, field(line, 6));
            errors++;
        end
        if (is_io && cycles != 2) begin
            $display("mismatch at %0t: I/O ack on line %0d after %0d cycles, expected 1",
                     $time, line, cycles - 1);
            errors++;
        end
        @(posedge clk);
        data_access <= 1'b0;
        data_io     <= 1'b0;
        data_req    <= '0;
    endtask

    // An ack must never show up on a port that is not requesting
    always @(negedge clk) begin
        if (arst_n && !instr_access && instr_rsp.ack) begin
            $display("ack on the idle instruction port at %0t", $time);
            other_errors++;
        end
        if (arst_n && !data_access && data_rsp.ack) begin
            $display("ack on the idle data port at %0t", $time);
            other_errors++;
        end
    end

    initial begin
        int i;
        int test;
        int first;
        int line;
        int passed;
        int failed;
        int instr_lines[$];
        int data_lines[$];
        arst_n       = 1'b0;
        instr_access = 1'b0;
        instr_req    = '0;
        data_access  = 1'b0;
        data_io      = 1'b0;
        data_req     = '0;
        passed       = 0;
        failed       = 0;
        void'($urandom(32'h0ed3_5b83));
        for (i = 0; i < fields*max_lines; i++) begin
            stim[i] = '1;   // End marker
        end
        $readmemh("tb/soc_stim.txt", stim);
        while (num_lines < max_lines && stim[num_lines*fields] !== 32'hffff_ffff) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("no stimulus lines could be read from tb/soc_stim.txt");
            other_errors++;
        end

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        first = 0;
        while (first < num_lines) begin
            test = field(first, 0);
            instr_lines.delete();
            data_lines.delete();
            line = first;
            while (line < num_lines && field(line, 0) == test) begin
                if (field(line, 1) == 0) begin
                    instr_lines.push_back(line);
                end else begin
                    data_lines.push_back(line);
                end
                line++;
            end
            errors = 0;
            fork
                begin
                    foreach (instr_lines[k]) begin
                        fetch(instr_lines[k]);
                    end
                end
                begin
                    foreach (data_lines[k]) begin
                        data_transfer(data_lines[k]);
                    end
                end
            join
            $display("test %0d: %0d transactions, %0d errors", test, line - first, errors);
            if (errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            first = line;
        end

        repeat (2) @(posedge clk);   // Let the last assertions sample
        $display("tests passed: %0d, tests failed: %0d, other errors: %0d",
                 passed, failed, other_errors + i_soc_top.i_soc_sva.fail_count);
        if (failed == 0 && other_errors == 0 && i_soc_top.i_soc_sva.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog budget grows with the stimulus length
    initial begin
        #1;
        repeat (num_lines * 20 + 100) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 num_lines * 20 + 100);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== tb/soc_stim.txt ====
// test port(0 instr, 1 data mem, 2 data io) rw(1 write) byte_addr wdata bytesel expected
// expected is read data, or the leds value after an I/O write; unused for memory writes
1 1 1 00100 1234 3 0000
1 1 1 00100 ab56 1 0000
1 1 0 00100 0000 3 1256
1 1 1 00100 cd78 2 0000
1 1 1 00100 ffff 0 0000
1 1 0 00100 0000 3 cd56
1 1 1 02200 5a5a 3 0000
1 1 0 00200 0000 3 5a5a
2 1 1 00000 0bad 3 0000
2 1 1 fc000 b105 3 0000
2 1 0 fc000 0000 3 b105
2 2 1 0ffec 0000 1 0000
2 2 0 0ffec 0000 3 0000
2 1 0 fc000 0000 3 0bad
2 2 1 0ffec 0001 1 0000
2 1 0 fc000 0000 3 b105
3 2 0 0ffec 0000 3 0001
3 2 1 0fffe 00a5 1 00a5
3 2 1 0fffe 3c00 2 00a5
3 2 1 0fffe 123c 3 003c
3 2 0 0fffe 0000 3 003c
4 2 0 00060 0000 3 0000
4 2 1 0fffc ffff 3 003c
4 2 0 0fffc 0000 3 0000
5 0 0 00100 0000 3 cd56
5 1 1 00400 1111 3 0000
5 0 1 00200 dead 3 5a5a
5 1 1 fc010 4444 3 0000
5 0 0 00200 0000 3 5a5a
5 1 0 00400 0000 3 1111
5 0 0 fc000 0000 3 b105
5 1 0 fc010 0000 3 4444
5 0 0 00000 0000 3 0bad
5 1 0 00200 0000 3 5a5a

// ==== flist.f ====
common/soc_pkg.sv
hw/onchip_ram.sv
hw/mem_arbiter.sv
hw/io_decoder.sv
hw/io_regs.sv
hw/soc_top.sv
tb/soc_sva.sv
tb/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - common/soc_pkg.sv
  - hw/onchip_ram.sv
  - hw/mem_arbiter.sv
  - hw/io_decoder.sv
  - hw/io_regs.sv
  - hw/soc_top.sv
  - target: test
    files:
      - tb/soc_sva.sv
      - tb/soc_tb.sv
